// File: flist.f
src/botPermutePkg.sv
src/variableSwapNet.sv
src/fastFifo.sv
src/burstControl.sv
src/botPermuter.sv
src/botInputTop.sv
tests/botInputTb.sv

// File: tests/botStimulus.txt
# test <name> <ready pattern, 16 hex bits, bit n drives cycle n mod 16>
# bot <botValid> <bot, 32 hex digits> <mask hex> <extra hex> | rand <entries>
# fill <fifoFullness> <outputs so far> | done (ready high, drain, report)
test identityOnly ffff
bot 1 0123456789abcdeffedcba9876543210 20 a5c
done
test fullMask ffff
bot 1 8000000000000000000000000000ff01 3f 3c3
done
test zeroMask ffff
bot 1 ffffffffffffffffffffffffffffffff 00 111
bot 0 e8e8e8e8e8e8e8e8e8e8e8e8e8e8e8e8 3f 222
fill 0 0
bot 1 0000000000000000deadbeefcafef00d 00 333
bot 0 96969696969696969696969696969696 21 444
bot 0 00000000000000000000000000000001 01 555
fill 0 0
done
test fillBackpressure 0000
bot 1 00000000000000000000000000000002 01 001
bot 1 000000000000000000000000000000f0 02 002
bot 1 0000000000000000000000000000aa55 04 003
bot 1 00000000000000001234567800000000 08 004
bot 1 fedcba98765432100000000000000000 10 005
bot 1 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 20 006
bot 1 33333333333333335555555555555555 03 007
bot 1 00ff00ff00ff00ff00ff00ff00ff00ff 30 008
bot 1 13572468ace0bdf913572468ace0bdf9 15 009
bot 1 80402010080402018040201008040201 2a 00a
fill 10 0
done
test stress 3c5a
rand 40
done

// File: tests/botInputTb.sv
`timescale 1ns/1ps

module botInputTb;

    import botPermutePkg::*;

    localparam int extraWidth = 12;

    logic                  clk;
    logic                  rst;
    botT                   bot;
    permMaskT              mask;
    logic [extraWidth-1:0] extraIn;
    logic                  botValid;
    logic [fifoDepthLog:0] fifoFullness;
    logic                  readyForBotBurst;
    logic                  outValid;
    permOutT               permOut;
    logic [extraWidth-1:0] extraOut;

    // expected outputs in the order they must leave the DUT
    permOutT               expOut [$];
    logic [extraWidth-1:0] expExtra [$];

    string       lines [$];
    string       testName;
    logic [15:0] readyPattern;
    logic        draining;  // ready forced high while a test drains
    logic        entryDriven;  // valid entry with a non-empty mask on the inputs
    logic        wroteEntry;
    int          prevFill;
    int          phase;
    int          cycleCount;
    int          cycleLimit;
    int          errorCount;
    int          testErrors;
    int          testOutputs;
    int          testExpected;
    int          testsRun;
    int          testsFailed;
    int          outputsChecked;

    botInputTop #(
        .extraWidth(extraWidth)
    ) dut_i (
        .clk             (clk),
        .rst             (rst),
        .bot             (bot),
        .mask            (mask),
        .extraIn         (extraIn),
        .botValid        (botValid),
        .fifoFullness    (fifoFullness),
        .readyForBotBurst(readyForBotBurst),
        .outValid        (outValid),
        .permOut         (permOut),
        .extraOut        (extraOut)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // letters XYZ: output position A takes input X, B takes Y, C takes Z
    function automatic logic [23:0] codeLetters(int code);
        case (code)
            5: return "ABC";
            4: return "ACB";
            3: return "BAC";
            2: return "BCA";
            1: return "CAB";
            0: return "CBA";
            default: return "ABC";
        endcase
    endfunction

    function automatic botT permuteRef(botT b, int code);
        logic [23:0] letters;
        logic [6:0]  src;
        botT         result;
        int          v;
        letters = codeLetters(code);
        for (int j = 0; j < 128; j++) begin
            src = 7'(j);  // D..G untouched
            for (int p = 0; p < 3; p++) begin
                v = letters[23 - 8 * p -: 8] - 8'h41;
                src[v] = j[p];
            end
            result[j] = b[src];
        end
        return result;
    endfunction

    task noteError();
        errorCount++;
        testErrors++;
    endtask

    // one expected output per set mask bit, highest code first
    task automatic expectEntry(botT b, permMaskT m, logic [extraWidth-1:0] e);
        permOutT item;
        for (int code = 5; code >= 0; code--) begin
            if (m[code]) begin
                item.bot  = permuteRef(b, code);
                item.code = permCodeT'(code);
                expOut.push_back(item);
                expExtra.push_back(e);
                testExpected++;
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        botValid         = 1'b0;
        entryDriven      = 1'b0;
        readyForBotBurst = draining ? 1'b1 : readyPattern[phase % 16];
        phase++;
    endtask

    task automatic driveEntry(logic v, botT b, permMaskT m, logic [extraWidth-1:0] e);
        stepCycle();
        while (fifoFullness[fifoDepthLog]) begin  // queue full, hold the write
            stepCycle();
        end
        bot         = b;
        mask        = m;
        extraIn     = e;
        botValid    = v;
        entryDriven = v && (m != '0);
        if (entryDriven) begin
            expectEntry(b, m, e);
        end
    endtask

    task automatic startTest(string name, logic [15:0] pattern);
        testName     = name;
        readyPattern = pattern;
        draining     = 1'b0;
        phase        = 0;
        testErrors   = 0;
        testOutputs  = 0;
        testExpected = 0;
        testsRun++;
    endtask

    task automatic checkFill(int fill, int outs);
        stepCycle();
        assert (fifoFullness == fill) else begin
            $display("CHECK FAILED %s fifoFullness expected %0d actual %0d",
                     testName, fill, fifoFullness);
            noteError();
        end
        assert (testOutputs == outs) else begin
            $display("CHECK FAILED %s output count expected %0d actual %0d",
                     testName, outs, testOutputs);
            noteError();
        end
    endtask

    task automatic finishTest();
        draining = 1'b1;
        stepCycle();
        while (expOut.size() != 0) begin  // every expected output seen
            stepCycle();
        end
        repeat (6) stepCycle();  // room for a stray output to show up
        assert (fifoFullness == 0) else begin
            $display("CHECK FAILED %s final fifoFullness expected 0 actual %0d",
                     testName, fifoFullness);
            noteError();
        end
        assert (testOutputs == testExpected) else begin
            $display("CHECK FAILED %s output count expected %0d actual %0d",
                     testName, testExpected, testOutputs);
            noteError();
        end
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("test %s: %0d outputs, %0d errors", testName, testOutputs, testErrors);
    endtask

    // outputs only move on rising edges, compare them mid-cycle
    always @(negedge clk) begin : outputMonitor
        permOutT               e;
        logic [extraWidth-1:0] x;
        if (!rst && outValid) begin
            testOutputs++;
            assert (expOut.size() != 0) else begin
                $display("unexpected output in test %s: code %0d with nothing pending",
                         testName, permOut.code);
                noteError();
            end
            if (expOut.size() != 0) begin
                e = expOut.pop_front();
                x = expExtra.pop_front();
                outputsChecked++;
                assert ({permOut, extraOut} == {e, x}) else begin
                    $display("CHECK FAILED %s expected %h_%h actual %h_%h",
                             testName, e, x, permOut, extraOut);
                    noteError();
                end
            end
        end
    end

    // what the rising edge saw on the input side
    always @(posedge clk) begin : writeSample
        wroteEntry = entryDriven;
    end

    // fill level only rises after a valid entry with a non-empty mask
    always @(negedge clk) begin : fillWatch
        if (!rst) begin
            assert (fifoFullness <= prevFill || wroteEntry) else begin
                $display("fifoFullness rose from %0d to %0d in test %s with no entry written",
                         prevFill, fifoFullness, testName);
                noteError();
            end
        end
        prevFill = fifoFullness;
    end

    always @(posedge clk) begin : timeoutWatch
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles in test %s: expected outputs never arrived",
                     cycleCount, testName);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin : stimulusRunner
        int                    fd;
        int                    n;
        int                    v;
        int                    count;
        int                    totalEntries;
        string                 line;
        string                 kw;
        string                 name;
        botT                   b;
        permMaskT              m;
        logic [extraWidth-1:0] e;
        logic [15:0]           pat;
        rst              = 1'b1;
        bot              = '0;
        mask             = '0;
        extraIn          = '0;
        botValid         = 1'b0;
        readyForBotBurst = 1'b0;
        readyPattern     = '0;
        draining         = 1'b0;
        entryDriven      = 1'b0;
        wroteEntry       = 1'b0;
        prevFill         = 0;
        phase            = 0;
        cycleCount       = 0;
        cycleLimit       = 0;
        errorCount       = 0;
        testErrors       = 0;
        testOutputs      = 0;
        testExpected     = 0;
        testsRun         = 0;
        testsFailed      = 0;
        outputsChecked   = 0;
        testName         = "reset";
        void'($urandom(32'h8cb84628));

        fd = $fopen("tests/botStimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/botStimulus.txt, no tests run");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end

        // timeout budget from the number of entries in the file
        totalEntries = 0;
        foreach (lines[i]) begin
            kw = "";
            n = $sscanf(lines[i], "%s %d", kw, v);
            if (kw == "bot") begin
                totalEntries++;
            end else if (kw == "rand" && n == 2) begin
                totalEntries += v;
            end
        end
        cycleLimit = totalEntries * 8 + 200;

        repeat (16) @(negedge clk);
        rst = 1'b0;

        foreach (lines[i]) begin
            kw = "";
            n = $sscanf(lines[i], "%s", kw);
            if (n < 1 || kw.substr(0, 0) == "#") begin
                // blank or comment line
            end else if (kw == "test") begin
                n = $sscanf(lines[i], "%s %s %h", kw, name, pat);
                startTest(name, pat);
            end else if (kw == "bot") begin
                n = $sscanf(lines[i], "%s %d %h %h %h", kw, v, b, m, e);
                driveEntry(v != 0, b, m, e);
            end else if (kw == "rand") begin
                n = $sscanf(lines[i], "%s %d", kw, count);
                for (int k = 0; k < count; k++) begin
                    b = {$urandom, $urandom, $urandom, $urandom};
                    m = permMaskT'($urandom % 64);
                    e = extraWidth'($urandom);
                    driveEntry(($urandom % 8) != 0, b, m, e);  // mostly valid
                end
            end else if (kw == "fill") begin
                n = $sscanf(lines[i], "%s %d %d", kw, v, count);
                checkFill(v, count);
            end else if (kw == "done") begin
                finishTest();
            end else begin
                $display("unknown record %s in stimulus file", kw);
                errorCount++;
            end
        end

        $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
                 testsRun, testsFailed, outputsChecked, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src/botInputTop.sv
`timescale 1ns/1ps

module botInputTop #(
    parameter int extraWidth = 12
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // input side
    input  botPermutePkg::botT                   bot,
    input  botPermutePkg::permMaskT              mask,
    input  logic [extraWidth-1:0]                extraIn,
    input  logic                                 botValid,
    output logic [botPermutePkg::fifoDepthLog:0] fifoFullness,

    // output side
    input  logic                                 readyForBotBurst,
    output logic                                 outValid,
    output botPermutePkg::permOutT               permOut,
    output logic [extraWidth-1:0]                extraOut
);

    import botPermutePkg::*;

    typedef struct packed {
        permJobT               job;
        logic [extraWidth-1:0] extra;
    } fifoEntryT;

    fifoEntryT             fifoIn;
    fifoEntryT             fifoOut;
    logic                  writeEnable;
    logic                  readRequest;
    logic                  fifoOutValid;
    logic                  startNewBurst;
    permJobT               burstJob;
    logic [extraWidth-1:0] burstExtra;

    assign fifoIn = '{job: '{bot: bot, mask: mask}, extra: extraIn};

    fastFifo #(
        .payloadT(fifoEntryT),
        .depthLog(fifoDepthLog)
    ) botQueue_i (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .dataIn      (fifoIn),
        .usedw       (fifoFullness),
        .readRequest (readRequest),
        .dataOut     (fifoOut),
        .dataOutValid(fifoOutValid)
    );

    burstControl #(
        .entryT    (fifoEntryT),
        .extraWidth(extraWidth)
    ) control_i (
        .clk             (clk),
        .rst             (rst),
        .botValid        (botValid),
        .mask            (mask),
        .writeEnable     (writeEnable),
        .readyForBotBurst(readyForBotBurst),
        .readRequest     (readRequest),
        .fifoData        (fifoOut),
        .fifoDataValid   (fifoOutValid),
        .startNewBurst   (startNewBurst),
        .job             (burstJob),
        .extra           (burstExtra)
    );

    botPermuter #(
        .extraWidth(extraWidth)
    ) permuter_i (
        .clk          (clk),
        .rst          (rst),
        .startNewBurst(startNewBurst),
        .job          (burstJob),
        .extraIn      (burstExtra),
        .outValid     (outValid),
        .permOut      (permOut),
        .extraOut     (extraOut)
    );

endmodule

// File: src/botPermuter.sv
`timescale 1ns/1ps

module botPermuter #(
    parameter int extraWidth = 12
) (
    input  logic                   clk,
    input  logic                   rst,

    // input side
    input  logic                   startNewBurst,
    input  botPermutePkg::permJobT job,
    input  logic [extraWidth-1:0]  extraIn,

    // output side
    output logic                   outValid,
    output botPermutePkg::permOutT permOut,
    output logic [extraWidth-1:0]  extraOut
);

    import botPermutePkg::*;

    // current burst
    botT                   curBot;
    permMaskT              remaining;
    logic [extraWidth-1:0] curExtra;

    // what gets walked this cycle
    botT                   selBot;
    permMaskT              selMask;
    logic [extraWidth-1:0] selExtra;
    permCodeT              topCode;
    logic                  anyLeft;
    botT                   swapped;

    // a new job bypasses the latches so its first output is one cycle out
    always_comb begin
        if (startNewBurst) begin
            selBot   = job.bot;
            selMask  = job.mask;
            selExtra = extraIn;
        end else begin
            selBot   = curBot;
            selMask  = remaining;
            selExtra = curExtra;
        end
    end

    // highest set bit wins, codes come out 5 down to 0
    always_comb begin
        topCode = '0;
        for (int k = 0; k < 6; k++) begin
            if (selMask[k]) begin
                topCode = permCodeT'(k);
            end
        end
        anyLeft = |selMask;
    end

    variableSwapNet swapNet_i (
        .botIn (selBot),
        .code  (topCode),
        .botOut(swapped)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            outValid  <= 1'b0;
        end else begin
            remaining <= selMask & ~(permMaskT'(1) << topCode);
            outValid  <= anyLeft;
        end
    end

    always_ff @(posedge clk) begin
        if (startNewBurst) begin
            curBot   <= job.bot;
            curExtra <= extraIn;
        end
        if (anyLeft) begin
            permOut.bot  <= swapped;
            permOut.code <= topCode;
            extraOut     <= selExtra;  // same word on every output of the burst
        end
    end

    // the countdown in burstControl must hold off the next job
    // until the current mask has been fully walked
    noBurstOverlap: assert property (
        @(posedge clk) disable iff (rst) startNewBurst |-> (remaining == '0)
    ) else $error("botPermuter: new burst while previous one still running");

endmodule

// File: src/burstControl.sv
`timescale 1ns/1ps

module burstControl #(
    parameter int  extraWidth = 12,
    parameter type entryT = struct packed {
        botPermutePkg::permJobT  job;
        logic [extraWidth-1:0]   extra;
    }
) (
    input  logic                    clk,
    input  logic                    rst,

    // input side
    input  logic                    botValid,
    input  botPermutePkg::permMaskT mask,
    output logic                    writeEnable,

    // fifo read side
    input  logic                    readyForBotBurst,
    output logic                    readRequest,
    input  entryT                   fifoData,
    input  logic                    fifoDataValid,

    // permuter side
    output logic                    startNewBurst,
    output botPermutePkg::permJobT  job,
    output logic [extraWidth-1:0]   extra
);

    import botPermutePkg::*;

    logic      popPending;  // pop issued last cycle, fifo output is live now
    logic      capValid;
    entryT     captured;
    logic [2:0] countdown;

    permMaskT   fifoMask;
    logic [1:0] lowHalf;
    logic [1:0] highHalf;
    logic [2:0] maskCount;

    // entries with nothing to emit never reach the queue
    assign writeEnable = botValid && (|mask);

    assign readRequest = readyForBotBurst && (countdown == '0) && !popPending;

    // popcount of the entry coming out of the fifo
    assign fifoMask  = fifoData.job.mask;
    assign lowHalf   = fifoMask[0] + fifoMask[1] + fifoMask[2];
    assign highHalf  = fifoMask[3] + fifoMask[4] + fifoMask[5];
    assign maskCount = lowHalf + highHalf;

    assign startNewBurst = capValid;
    assign job           = captured.job;
    assign extra         = captured.extra;

    always_ff @(posedge clk) begin
        if (rst) begin
            popPending <= 1'b0;
            capValid   <= 1'b0;
            countdown  <= '0;
        end else begin
            popPending <= readRequest;
            capValid   <= popPending && fifoDataValid;
            // armed as the entry is captured, so the next pop lands
            // two cycles before this burst runs dry
            if (popPending && fifoDataValid) begin
                countdown <= (maskCount > 3'd2) ? maskCount - 3'd2 : 3'd0;
            end else if (countdown != '0) begin
                countdown <= countdown - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (popPending) begin
            captured <= fifoData;  // held until the next pop returns
        end
    end

    // zero masks are filtered at the write port, so none may come back out
    noEmptyBurst: assert property (
        @(posedge clk) disable iff (rst) startNewBurst |-> (job.mask != '0)
    ) else $error("burstControl: burst started with an empty mask");

endmodule

// File: src/fastFifo.sv
`timescale 1ns/1ps

module fastFifo #(
    parameter type payloadT = logic [31:0],
    parameter int  depthLog = 4
) (
    input  logic              clk,
    input  logic              rst,

    // write side
    input  logic              writeEnable,
    input  payloadT           dataIn,
    output logic [depthLog:0] usedw,

    // read side
    input  logic              readRequest,
    output payloadT           dataOut,
    output logic              dataOutValid
);

    localparam int depth = 1 << depthLog;

    payloadT mem [depth];

    logic [depthLog-1:0] wrPtr;
    logic [depthLog-1:0] rdPtr;
    logic                full;
    logic                empty;
    logic                doWrite;
    logic                doRead;

    assign full    = usedw[depthLog];  // count == depth
    assign empty   = (usedw == '0);
    assign doWrite = writeEnable && !full;
    assign doRead  = readRequest && !empty;

    // pointers, count and read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            usedw        <= '0;
            dataOutValid <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            usedw        <= usedw + {{depthLog{1'b0}}, doWrite} - {{depthLog{1'b0}}, doRead};
            dataOutValid <= doRead;  // low when popped while empty
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= dataIn;
        end
        if (doRead) begin
            dataOut <= mem[rdPtr];
        end
    end

    // upstream must watch the fill level, a write while full is lost
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (rst) writeEnable |-> !full
    ) else $error("fastFifo: write while full, entry dropped");

endmodule

// File: src/variableSwapNet.sv
`timescale 1ns/1ps

module variableSwapNet (
    input  botPermutePkg::botT     botIn,
    input  botPermutePkg::permCodeT code,
    output botPermutePkg::botT     botOut
);

    import botPermutePkg::*;

    // source index for output index j: the input variable feeding
    // position A takes j[0], the one feeding B takes j[1], C takes j[2]
    function automatic logic [6:0] srcIndex(logic [6:0] j, permCodeT c);
        logic [1:0] posA;
        logic [1:0] posB;
        logic [1:0] posC;
        logic [6:0] src;
        case (c)
            codeAbc: {posA, posB, posC} = {2'd0, 2'd1, 2'd2};
            codeAcb: {posA, posB, posC} = {2'd0, 2'd2, 2'd1};
            codeBac: {posA, posB, posC} = {2'd1, 2'd0, 2'd2};
            codeBca: {posA, posB, posC} = {2'd1, 2'd2, 2'd0};
            codeCab: {posA, posB, posC} = {2'd2, 2'd0, 2'd1};
            codeCba: {posA, posB, posC} = {2'd2, 2'd1, 2'd0};
            default: {posA, posB, posC} = {2'd0, 2'd1, 2'd2};
        endcase
        src       = j;  // D..G stay in place
        src[posA] = j[0];
        src[posB] = j[1];
        src[posC] = j[2];
        return src;
    endfunction

    botT perms [6];

    // six fixed wirings of the table, no logic inside
    for (genvar k = 0; k < 6; k++) begin : gCode
        for (genvar j = 0; j < 128; j++) begin : gBit
            assign perms[k][j] = botIn[srcIndex(7'(j), permCodeT'(k))];
        end
    end

    // codes 6 and 7 are never issued, pass through
    assign botOut = (code <= codeAbc) ? perms[code] : botIn;

endmodule

// File: src/botPermutePkg.sv
package botPermutePkg;

    // truth table of a 7-input function, bit i is f(i), A/B/C are index bits 0/1/2
    typedef logic [127:0] botT;

    // one bit per wanted permutation, bit k selects code k
    typedef logic [5:0] permMaskT;

    typedef logic [2:0] permCodeT;

    // letters name the input variables that feed output positions A, B, C
    localparam permCodeT codeAbc = 3'd5;  // identity
    localparam permCodeT codeAcb = 3'd4;
    localparam permCodeT codeBac = 3'd3;
    localparam permCodeT codeBca = 3'd2;
    localparam permCodeT codeCab = 3'd1;
    localparam permCodeT codeCba = 3'd0;

    // one queued job, 134 bits
    typedef struct packed {
        botT      bot;
        permMaskT mask;
    } permJobT;

    // one permuted result, 131 bits
    typedef struct packed {
        botT      bot;
        permCodeT code;
    } permOutT;

    // 16-entry input queue
    localparam int fifoDepthLog = 4;

endpackage
